/* flist.f */
mips_dbg_pkg.sv
uart.sv
debug_unit.sv
data_path.sv
mips_debug_top.sv
tb_mips_debug_top_asserts.sv
tb_mips_debug_top.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_mips_debug_top -o sim_tb_mips_debug_top \
    && ./obj_dir/sim_tb_mips_debug_top || exit 1

/* tb_mips_debug_top.sv */
`timescale 1ns/1ps

module tb_mips_debug_top
    import mips_dbg_pkg::*;
();

    localparam int PROG1_LEN  = 10;   // Random ALU words before the HALT
    localparam int PROG2_LEN  = 16;
    localparam int DUMP_BYTES = 4 * (1 + 2**REG_ADDR_W + 2**DM_ADDR_W);
    localparam int TEST_BYTES = 1 + (2 + 4 * (PROG1_LEN + 1)) + (2 + 4 * (PROG2_LEN + 1))
                                + 6 * (1 + DUMP_BYTES);
    localparam int RX_TIMEOUT = 1000;  // Cycles allowed before a start bit

    logic        clock;
    logic        rst_n;
    logic        host_tx;              // Host to DUT serial line
    logic        dut_tx;
    logic        hlt;
    du_state_t   state;
    logic [31:0] lfsr;
    word_t       prog [64];
    word_t       m_rb [2**REG_ADDR_W];
    word_t       m_dm [2**DM_ADDR_W];
    word_t       m_pc;
    logic        m_hlt;
    word_t       dut_pc;               // PC from the last dump

    mips_debug_top i_mips_debug_top (
        .i_clock      (clock),
        .i_rst_n      (rst_n),
        .i_uart_du_rx (host_tx),
        .o_uart_du_tx (dut_tx),
        .o_hlt        (hlt),
        .o_state      (state)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        #(TEST_BYTES * 10 * CLKS_PER_BIT * 8 * 2);
        fail_run("Watchdog expired before the tests completed");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            fail_run("Value check failed");
        end
    endtask

    function automatic logic [31:0] galois_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galois_lfsr(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t enc_imm(input logic [5:0] op, input reg_addr_t rs,
                                      input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_addu(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, FUNCT_ADDU};
    endfunction

    task automatic apply_reset();
        @(posedge clock);
        rst_n <= 1'b0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            m_rb[i] = '0;
            m_dm[i] = '0;
        end
        m_pc  = '0;
        m_hlt = 1'b0;
    endtask

    // One instruction of the reference ISA
    task automatic model_exec();
        word_t      ins;
        word_t      simm;
        word_t      ea;
        logic [5:0] op;
        ins  = prog[m_pc[7:2]];
        op   = ins[31:26];
        simm = {{16{ins[15]}}, ins[15:0]};
        ea   = m_rb[ins[25:21]] + simm;
        if (op == OP_HALT) begin
            m_hlt = 1'b1;              // PC stays on the halt
        end else begin
            case (op)
                OP_RTYPE: begin
                    if (ins[5:0] == FUNCT_ADDU) begin
                        m_rb[ins[15:11]] = m_rb[ins[25:21]] + m_rb[ins[20:16]];
                    end
                end
                OP_ADDI: m_rb[ins[20:16]] = ea;
                OP_LW:   m_rb[ins[20:16]] = m_dm[ea[6:2]];
                OP_SW:   m_dm[ea[6:2]] = m_rb[ins[20:16]];
                default: ;
            endcase
            m_rb[0] = '0;
            m_pc    = m_pc + 32'd4;
        end
    endtask

    task automatic uart_send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};       // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            host_tx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
    endtask

    task automatic uart_recv_byte(output byte_t b);
        int waited;
        waited = 0;
        @(negedge clock);
        while (dut_tx !== 1'b0) begin
            waited++;
            if (waited > RX_TIMEOUT) begin
                fail_run("No start bit came from the DUT in time");
            end
            @(negedge clock);
        end
        repeat (CLKS_PER_BIT / 2) @(negedge clock);    // Mid start bit
        if (dut_tx !== 1'b0) begin
            fail_run("Start bit from the DUT was too short");
        end
        for (int i = 0; i < BYTE_W; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clock);
            b[i] = dut_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clock);
        if (dut_tx !== 1'b1) begin
            fail_run("Stop bit from the DUT was missing");
        end
    endtask

    task automatic recv_word(output word_t w);
        byte_t b;
        w = '0;
        for (int k = 0; k < 4; k++) begin
            uart_recv_byte(b);
            w = {w[23:0], b};          // MSB first
        end
    endtask

    task automatic check_dump(input string tag);
        word_t w;
        recv_word(w);
        dut_pc = w;
        check_value({tag, " pc"}, w, m_pc);
        for (int i = 0; i < 2**REG_ADDR_W; i++) begin
            recv_word(w);
            check_value($sformatf("%s register %0d", tag, i), w, m_rb[i]);
        end
        for (int i = 0; i < 2**DM_ADDR_W; i++) begin
            recv_word(w);
            check_value($sformatf("%s memory word %0d", tag, i), w, m_dm[i]);
        end
    endtask

    task automatic load_program(input int words);
        byte_t ack;
        uart_send_byte(CMD_LOAD);
        for (int i = 0; i < words; i++) begin
            for (int k = 3; k >= 0; k--) begin
                uart_send_byte(prog[i][8*k +: 8]);
            end
        end
        uart_recv_byte(ack);
        check_value("load ack", 32'(ack), 32'(ACK_LOAD));
        m_pc = '0;
    endtask

    task automatic step_and_check(input string tag);
        uart_send_byte(CMD_STEP);
        if (!m_hlt) begin
            model_exec();
        end
        check_dump(tag);
    endtask

    task automatic idle_after_reset();
        @(negedge clock);
        check_value("o_state", 32'(state), 32'(ST_IDLE));
        check_value("o_hlt", 32'(hlt), 0);
        check_value("o_uart_du_tx", 32'(dut_tx), 1);
        uart_send_byte(8'h5A);         // Not a command
        repeat (12) begin
            @(negedge clock);
            check_value("o_state after junk byte", 32'(state), 32'(ST_IDLE));
        end
    endtask

    task automatic load_alu_program();
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        for (int i = 0; i < PROG1_LEN; i++) begin
            rs  = reg_addr_t'(rand_bits(REG_ADDR_W));
            rt  = reg_addr_t'(rand_bits(REG_ADDR_W));
            rd  = reg_addr_t'(rand_bits(REG_ADDR_W));
            imm = 16'(rand_bits(16));
            if (rand_bits(1) == 32'd1) begin
                prog[i] = enc_imm(OP_ADDI, rs, rt, imm);
            end else begin
                prog[i] = enc_addu(rs, rt, rd);
            end
        end
        prog[PROG1_LEN] = {OP_HALT, 26'd0};
        load_program(PROG1_LEN + 1);
    endtask

    task automatic step_three_times();
        word_t prev_pc;
        for (int i = 0; i < 3; i++) begin
            prev_pc = m_pc;
            step_and_check($sformatf("step %0d", i));
            check_value("pc after step", dut_pc, prev_pc + 32'd4);
        end
    endtask

    task automatic run_to_halt();
        uart_send_byte(CMD_RUN);
        while (!m_hlt) begin
            model_exec();
        end
        check_dump("run");
        check_value("pc at halt", dut_pc, 32'(4 * PROG1_LEN));
        @(negedge clock);
        check_value("o_hlt after run", 32'(hlt), 1);
    endtask

    task automatic memory_program();
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        logic [1:0]  sel;
        apply_reset();                 // Only reset clears hlt
        for (int i = 0; i < PROG2_LEN; i++) begin
            // Seed a few registers first, then ADDI, SW, LW and ADDU in turn
            sel = (i < 4) ? 2'd0 : 2'(i);
            if (sel != 2'd2) begin     // LW reads back the word just stored
                rs  = reg_addr_t'(rand_bits(REG_ADDR_W));
                imm = 16'(rand_bits(16));
            end
            if (sel != 2'd1) begin     // SW stores the ADDI result
                rt = reg_addr_t'(rand_bits(REG_ADDR_W));
            end
            rd  = reg_addr_t'(rand_bits(REG_ADDR_W));
            case (sel)
                2'd0:    prog[i] = enc_imm(OP_ADDI, rs, rt, imm);
                2'd1:    prog[i] = enc_imm(OP_SW, rs, rt, imm);
                2'd2:    prog[i] = enc_imm(OP_LW, rs, rt, imm);
                default: prog[i] = enc_addu(rs, rt, rd);
            endcase
        end
        prog[PROG2_LEN] = {OP_HALT, 26'd0};
        load_program(PROG2_LEN + 1);
        uart_send_byte(CMD_RUN);
        while (!m_hlt) begin
            model_exec();
        end
        check_dump("memory run");
    endtask

    task automatic step_while_halted();
        word_t halt_pc;
        halt_pc = m_pc;
        step_and_check("halted step");
        check_value("pc of halted step", dut_pc, halt_pc);
        @(negedge clock);
        check_value("o_hlt after halted step", 32'(hlt), 1);
    endtask

    initial begin
        rst_n   = 1'b0;
        host_tx = 1'b1;                // Line idles high
        lfsr    = 32'hdd30405f;
        apply_reset();
        idle_after_reset();
        load_alu_program();
        step_three_times();
        run_to_halt();
        memory_program();
        step_while_halted();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb_mips_debug_top_asserts.sv */
`timescale 1ns/1ps

module tb_mips_debug_top_asserts
    import mips_dbg_pkg::*;
(
    input logic       i_clock,
    input logic       i_rst_n,
    input logic       i_tx_start,
    input logic       i_tx_done,
    input du_ctrl_t   i_ctrl,
    input dp_status_t i_status
);

    logic tx_busy;   // From a start pulse to its done tick

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_busy <= 1'b0;
        end else if (i_tx_start) begin
            tx_busy <= 1'b1;
        end else if (i_tx_done) begin
            tx_busy <= 1'b0;
        end
    end

    hlt_sticky: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_status.hlt |=> i_status.hlt)
        else $error("hlt fell without a reset");

    tx_start_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_tx_start |-> !tx_busy)
        else $error("tx_start pulsed while the transmitter was busy");

    pc_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !i_ctrl.pc_enable && !i_ctrl.pc_clear |=> $stable(i_status.pc))
        else $error("PC changed while pc_enable was low");

    no_enable_halted: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        !(i_ctrl.pc_enable && i_status.hlt))
        else $error("pc_enable set while hlt was high");

endmodule

bind mips_debug_top tb_mips_debug_top_asserts asserts_1 (
    .i_clock    (i_clock),
    .i_rst_n    (i_rst_n),
    .i_tx_start (tx_start),
    .i_tx_done  (tx_done),
    .i_ctrl     (du_ctrl),
    .i_status   (dp_status)
);

/* mips_debug_top.sv */
`timescale 1ns/1ps

module mips_debug_top
    import mips_dbg_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_rst_n,
    input  logic      i_uart_du_rx,
    output logic      o_uart_du_tx,
    output logic      o_hlt,
    output du_state_t o_state
);

    byte_t      rx_data;
    byte_t      tx_data;
    logic       rx_done;
    logic       tx_done;
    logic       tx_start;
    du_ctrl_t   du_ctrl;
    dp_status_t dp_status;

    uart uart_debug_unit (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rx       (i_uart_du_rx),
        .i_tx_data  (tx_data),
        .i_tx_start (tx_start),
        .o_rx_data  (rx_data),
        .o_rx_done  (rx_done),
        .o_tx       (o_uart_du_tx),
        .o_tx_done  (tx_done)
    );

    debug_unit debug_unit_1 (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .i_status   (dp_status),
        .o_ctrl     (du_ctrl),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .o_state    (o_state)
    );

    data_path data_path_1 (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_ctrl   (du_ctrl),
        .o_status (dp_status)
    );

    assign o_hlt = dp_status.hlt;

endmodule

/* data_path.sv */
`timescale 1ns/1ps

module data_path
    import mips_dbg_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  du_ctrl_t   i_ctrl,
    output dp_status_t o_status
);

    byte_t      im [2**IM_ADDR_W];
    word_t      rb [2**REG_ADDR_W];
    word_t      dm [2**DM_ADDR_W];
    word_t      pc;
    logic       hlt;
    im_addr_t   fetch_addr;
    word_t      instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      simm;
    word_t      sum_imm;
    dm_addr_t   dm_idx;
    logic       exec;
    logic       rb_we;
    logic       dm_we;
    reg_addr_t  rb_wa;
    word_t      rb_wd;

    always_ff @(posedge i_clock) begin
        if (i_ctrl.im_write_enable) begin
            im[i_ctrl.im_addr] <= i_ctrl.im_data;
        end
    end

    // Big endian fetch
    assign fetch_addr = pc[IM_ADDR_W-1:0];
    assign instr = {im[fetch_addr], im[fetch_addr + 8'd1],
                    im[fetch_addr + 8'd2], im[fetch_addr + 8'd3]};

    assign opcode  = instr[31:26];
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign rd      = instr[15:11];
    assign funct   = instr[5:0];
    assign simm    = {{16{instr[15]}}, instr[15:0]};
    assign sum_imm = rb[rs] + simm;
    assign dm_idx  = sum_imm[6:2];        // Word index
    assign exec    = i_ctrl.pc_enable && !hlt;

    always_comb begin
        rb_we = 1'b0;
        dm_we = 1'b0;
        rb_wa = rt;
        rb_wd = sum_imm;
        case (opcode)
            OP_RTYPE: begin
                if (funct == FUNCT_ADDU) begin
                    rb_we = 1'b1;
                    rb_wa = rd;
                    rb_wd = rb[rs] + rb[rt];
                end
            end
            OP_ADDI: rb_we = 1'b1;
            OP_LW: begin
                rb_we = 1'b1;
                rb_wd = dm[dm_idx];
            end
            OP_SW:   dm_we = 1'b1;
            default: ;                            // No-op
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc  <= '0;
            hlt <= 1'b0;
        end else if (i_ctrl.pc_clear) begin
            pc <= '0;
        end else if (exec) begin
            if (opcode == OP_HALT) begin
                hlt <= 1'b1;                      // PC stays on the halt
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                rb[i] <= '0;
            end
        end else if (exec && rb_we && rb_wa != '0) begin   // R0 stays zero
            rb[rb_wa] <= rb_wd;
        end
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**DM_ADDR_W; i++) begin
                dm[i] <= '0;
            end
        end else if (exec && dm_we) begin
            dm[dm_idx] <= rb[rt];
        end
    end

    always_comb begin
        o_status.hlt     = hlt;
        o_status.pc      = pc;
        o_status.rb_data = rb[i_ctrl.rb_addr];
        o_status.dm_data = dm[i_ctrl.dm_addr];
    end

endmodule

/* debug_unit.sv */
`timescale 1ns/1ps

module debug_unit
    import mips_dbg_pkg::*;
(
    input  logic       i_clock,
    input  logic       i_rst_n,
    input  byte_t      i_rx_data,
    input  logic       i_rx_done,
    input  logic       i_tx_done,
    input  dp_status_t i_status,
    output du_ctrl_t   o_ctrl,
    output byte_t      o_tx_data,
    output logic       o_tx_start,
    output du_state_t  o_state
);

    du_state_t                state;
    im_addr_t                 load_addr;
    logic [WORD_W-BYTE_W-1:0] load_word;   // Bytes already taken of this word
    word_t                    cur_word;
    logic                     dumping;
    logic [6:0]               word_idx;    // 0 PC, 1..32 registers, 33..64 memory
    logic [6:0]               word_nxt;
    logic [1:0]               byte_idx;
    logic                     last_byte;
    word_t                    dump_word;

    function automatic du_state_t dump_state(input logic [6:0] idx);
        if (idx == 7'd0) begin
            return ST_DUMP_PC;
        end else if (idx <= 7'd32) begin
            return ST_DUMP_RB;
        end
        return ST_DUMP_DM;
    endfunction

    assign cur_word  = {load_word, i_rx_data};
    assign word_nxt  = (byte_idx == 2'd3) ? word_idx + 7'd1 : word_idx;
    assign last_byte = (byte_idx == 2'd3) && (word_idx == 7'd64);  // Byte 260

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            load_addr <= '0;
            load_word <= '0;
            dumping   <= 1'b0;
            word_idx  <= '0;
            byte_idx  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD: begin
                                load_addr <= '0;
                                state     <= ST_LOAD_BYTE;
                            end
                            CMD_RUN:  state <= ST_RUN;
                            CMD_STEP: state <= ST_STEP;
                            default: ;                // Not a command
                        endcase
                    end
                end
                ST_LOAD_BYTE: begin
                    if (i_rx_done) begin
                        load_addr <= load_addr + 1'b1;
                        load_word <= cur_word[WORD_W-BYTE_W-1:0];
                        if (load_addr[1:0] == 2'd3 && cur_word[31:26] == OP_HALT) begin
                            state <= ST_LOAD_ACK;
                        end
                    end
                end
                ST_LOAD_ACK: state <= ST_TX_WAIT;
                ST_RUN, ST_STEP: begin
                    // Step always leaves after one cycle
                    if (state == ST_STEP || i_status.hlt) begin
                        dumping  <= 1'b1;
                        word_idx <= '0;
                        byte_idx <= '0;
                        state    <= ST_DUMP_PC;
                    end
                end
                ST_DUMP_PC, ST_DUMP_RB, ST_DUMP_DM: state <= ST_TX_WAIT;
                ST_TX_WAIT: begin
                    if (i_tx_done) begin
                        if (!dumping || last_byte) begin
                            dumping <= 1'b0;
                            state   <= ST_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            word_idx <= word_nxt;
                            state    <= dump_state(word_nxt);
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        o_ctrl.pc_enable       = (state == ST_RUN || state == ST_STEP) && !i_status.hlt;
        o_ctrl.pc_clear        = (state == ST_IDLE) && i_rx_done && (i_rx_data == CMD_LOAD);
        o_ctrl.im_write_enable = (state == ST_LOAD_BYTE) && i_rx_done;
        o_ctrl.im_addr         = load_addr;
        o_ctrl.im_data         = i_rx_data;
        o_ctrl.rb_addr         = reg_addr_t'(word_idx - 7'd1);
        o_ctrl.dm_addr         = dm_addr_t'(word_idx - 7'd33);
    end

    always_comb begin
        case (state)
            ST_DUMP_PC: dump_word = i_status.pc;
            ST_DUMP_RB: dump_word = i_status.rb_data;
            default:    dump_word = i_status.dm_data;
        endcase
    end

    // MSB first
    assign o_tx_data  = (state == ST_LOAD_ACK) ? ACK_LOAD :
                        dump_word[{~byte_idx, 3'b000} +: BYTE_W];
    assign o_tx_start = (state == ST_LOAD_ACK) || (state == ST_DUMP_PC) ||
                        (state == ST_DUMP_RB)  || (state == ST_DUMP_DM);
    assign o_state    = state;

endmodule

/* uart.sv */
`timescale 1ns/1ps

module uart
    import mips_dbg_pkg::*;
(
    input  logic  i_clock,
    input  logic  i_rst_n,
    input  logic  i_rx,
    input  byte_t i_tx_data,
    input  logic  i_tx_start,
    output byte_t o_rx_data,
    output logic  o_rx_done,
    output logic  o_tx,
    output logic  o_tx_done
);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} uart_st_t;

    logic [1:0]                      rx_meta;
    logic                            rx_s;
    uart_st_t                        rx_st;
    uart_st_t                        tx_st;
    logic [$clog2(CLKS_PER_BIT)-1:0] rx_cnt;
    logic [$clog2(CLKS_PER_BIT)-1:0] tx_cnt;
    logic [2:0]                      rx_bits;
    logic [2:0]                      tx_bits;
    byte_t                           rx_shift;
    byte_t                           tx_shift;

    // Line idles high
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 2'b11;
        end else begin
            rx_meta <= {rx_meta[0], i_rx};
        end
    end

    assign rx_s = rx_meta[1];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_st     <= S_IDLE;
            rx_cnt    <= '0;
            rx_bits   <= '0;
            rx_shift  <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= 1'b0;
            case (rx_st)
                S_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_s) begin
                        rx_st <= S_START;
                    end
                end
                S_START: begin
                    if (rx_cnt == CLKS_PER_BIT/2 - 1) begin  // Mid start bit
                        rx_cnt  <= '0;
                        rx_bits <= '0;
                        rx_st   <= rx_s ? S_IDLE : S_DATA;  // Glitch drops back
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (rx_cnt == CLKS_PER_BIT - 1) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_s, rx_shift[BYTE_W-1:1]};  // LSB first
                        rx_bits  <= rx_bits + 1'b1;
                        if (rx_bits == 3'd7) begin
                            rx_st <= S_STOP;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt == CLKS_PER_BIT - 1) begin
                        rx_st     <= S_IDLE;
                        o_rx_done <= rx_s;    // Framing error gives no tick
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign o_rx_data = rx_shift;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_st     <= S_IDLE;
            tx_cnt    <= '0;
            tx_bits   <= '0;
            tx_shift  <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (tx_st == S_IDLE) begin
                tx_cnt <= '0;
                if (i_tx_start) begin
                    tx_shift <= i_tx_data;
                    tx_st    <= S_START;
                end
            end else if (tx_cnt != CLKS_PER_BIT - 1) begin
                tx_cnt <= tx_cnt + 1'b1;
            end else begin
                tx_cnt <= '0;
                case (tx_st)
                    S_START: begin
                        tx_bits <= '0;
                        tx_st   <= S_DATA;
                    end
                    S_DATA: begin
                        tx_shift <= tx_shift >> 1;
                        tx_bits  <= tx_bits + 1'b1;
                        if (tx_bits == 3'd7) begin
                            tx_st <= S_STOP;
                        end
                    end
                    default: begin
                        tx_st     <= S_IDLE;
                        o_tx_done <= 1'b1;   // End of stop bit
                    end
                endcase
            end
        end
    end

    assign o_tx = (tx_st == S_START) ? 1'b0 :
                  (tx_st == S_DATA)  ? tx_shift[0] : 1'b1;

endmodule

/* mips_dbg_pkg.sv */
package mips_dbg_pkg;

    localparam int BYTE_W       = 8;
    localparam int WORD_W       = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int DM_ADDR_W    = 5;
    localparam int IM_ADDR_W    = 8;   // 256 bytes, 64 instructions
    localparam int CLKS_PER_BIT = 4;

    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DM_ADDR_W-1:0]  dm_addr_t;
    typedef logic [IM_ADDR_W-1:0]  im_addr_t;

    // Opcodes and functs
    localparam logic [5:0] OP_RTYPE   = 6'h00;
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;
    localparam logic [5:0] OP_HALT    = 6'h3F;

    localparam byte_t CMD_LOAD = 8'h4C;    // "L"
    localparam byte_t CMD_RUN  = 8'h52;    // "R"
    localparam byte_t CMD_STEP = 8'h53;    // "S"
    localparam byte_t ACK_LOAD = 8'h4B;    // "K"

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD_BYTE,
        ST_LOAD_ACK,
        ST_RUN,
        ST_STEP,
        ST_DUMP_PC,
        ST_DUMP_RB,
        ST_DUMP_DM,
        ST_TX_WAIT
    } du_state_t;

    typedef struct packed {
        logic      pc_enable;
        logic      pc_clear;
        logic      im_write_enable;
        im_addr_t  im_addr;
        byte_t     im_data;
        reg_addr_t rb_addr;   // Debug read of the register bank
        dm_addr_t  dm_addr;   // Debug read of data memory
    } du_ctrl_t;

    typedef struct packed {
        logic  hlt;
        word_t pc;
        word_t rb_data;
        word_t dm_data;
    } dp_status_t;

endpackage
